//--- switch_params.svh
`ifndef SWITCH_PARAMS_SVH
`define SWITCH_PARAMS_SVH

// ==================================================
// Switch dimensions
// ==================================================

// Input ports, each with its own FIFO
`define SW_NUM_PORTS 4

// Payload bits carried by one packet word
`define SW_DATA_WIDTH 16

// Entries per port FIFO, must be a power of two
`define SW_FIFO_DEPTH 8

`endif

//--- switch_pkg.sv
`default_nettype none

`include "switch_params.svh"

package switch_pkg;

    // ==================================================
    // Port addressing
    // ==================================================

    // Number of one input port
    typedef logic [$clog2(`SW_NUM_PORTS)-1:0] port_idx_t;

    // One bit per input port, bit i belongs to port i
    typedef logic [`SW_NUM_PORTS-1:0] port_vec_t;

    // ==================================================
    // Packet words
    // ==================================================

    typedef struct packed {
        logic [`SW_DATA_WIDTH-1:0] data;
        logic                      last;  // Final word of the packet
    } pkt_word_t;

endpackage

`default_nettype wire

//--- sw_fifo.sv
`default_nettype none

`include "switch_params.svh"

module sw_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `SW_FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     wr_en,
    input  payload_t wr_data,

    input  logic     rd_en,
    output payload_t rd_data,

    output logic     empty,
    output logic     full
);

    localparam int AW = $clog2(DEPTH);

    payload_t        mem [DEPTH];
    logic     [AW:0] wr_ptr;
    logic     [AW:0] rd_ptr;

    // ==================================================
    // Pointers
    // ==================================================

    // The extra top bit tells a full buffer from an empty one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

    assign rd_data = mem[rd_ptr[AW-1:0]];  // Head is visible without a pop

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // ==================================================
    // Checks
    // ==================================================

    // The writer must look at full before it writes
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) !(wr_en && full)
    ) else $error("sw_fifo: write while full");

    // The drain engine may only pop a FIFO that holds a word
    a_no_read_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n) !(rd_en && empty)
    ) else $error("sw_fifo: read while empty");

endmodule

`default_nettype wire

//--- service_ctrl.sv
`default_nettype none

`include "switch_params.svh"

module service_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,

    input  switch_pkg::port_vec_t fifo_empty,
    input  logic                  drain_busy,
    input  switch_pkg::port_vec_t release_vec,

    output switch_pkg::port_idx_t grant_sel,
    output logic                  grant,
    output logic                  idle
);

    import switch_pkg::*;

    port_vec_t captured;     // Port has been seen with data and is not yet released
    port_vec_t pending;      // Captured port still waiting for its grant
    port_vec_t capture_set;
    port_vec_t grant_clr;
    port_idx_t scan_idx;
    logic      scan_hit;
    logic      grant_go;
    logic      idle_n;

    // ==================================================
    // Capture
    // ==================================================

    // A port is captured once and stays so until its packet has left
    assign capture_set = ~fifo_empty & ~captured;

    // ==================================================
    // Priority scan
    // ==================================================

    always_comb begin
        scan_hit = 1'b0;
        scan_idx = '0;
        for (int i = 0; i < `SW_NUM_PORTS; i++) begin
            if (pending[i] && !scan_hit) begin
                scan_hit = 1'b1;
                scan_idx = port_idx_t'(i);  // Lowest index wins
            end
        end
    end

    // The pulse itself also blocks, since drain_busy rises one cycle after it
    assign grant_go  = !drain_busy && !grant && scan_hit;
    assign grant_clr = grant_go ? (port_vec_t'(1) << scan_idx) : '0;

    assign idle_n = !(|pending) && !drain_busy && !grant;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            captured  <= '0;
            pending   <= '0;
            grant_sel <= '0;
            grant     <= 1'b0;
            idle      <= 1'b1;
        end else begin
            captured <= (captured | capture_set) & ~release_vec;
            pending  <= (pending | capture_set) & ~grant_clr;
            grant    <= grant_go;
            if (grant_go) begin
                grant_sel <= scan_idx;
            end
            idle <= idle_n;
        end
    end

    // Pending is only ever set together with captured and never outlives it
    a_pending_captured: assert property (
        @(posedge clk) disable iff (!rst_n) (pending & ~captured) == '0
    ) else $error("service_ctrl: pending port that is not captured");

endmodule

`default_nettype wire

//--- drain_engine.sv
`default_nettype none

`include "switch_params.svh"

module drain_engine (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  grant,
    input  switch_pkg::port_idx_t grant_sel,

    input  switch_pkg::pkt_word_t fifo_head [`SW_NUM_PORTS],
    input  switch_pkg::port_vec_t fifo_empty,
    input  logic                  out_stall,

    output switch_pkg::port_vec_t pop,
    output switch_pkg::port_vec_t release_vec,
    output logic                  drain_busy,

    output switch_pkg::pkt_word_t out_word,
    output logic                  out_valid,
    output switch_pkg::port_idx_t out_port
);

    import switch_pkg::*;

    port_idx_t active;   // Port whose packet is being drained
    pkt_word_t head;
    port_vec_t active_bit;
    logic      pop_en;

    // ==================================================
    // Output mux and pop
    // ==================================================

    assign head       = fifo_head[active];
    assign active_bit = port_vec_t'(1) << active;

    // The FIFO may run dry in the middle of a packet while the writer catches up
    assign pop_en = drain_busy && !out_stall && !fifo_empty[active];
    assign pop    = pop_en ? active_bit : '0;

    // ==================================================
    // Control state
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drain_busy  <= 1'b0;
            active      <= '0;
            out_valid   <= 1'b0;
            release_vec <= '0;
        end else begin
            out_valid   <= pop_en;
            release_vec <= '0;
            if (grant) begin
                drain_busy <= 1'b1;
                active     <= grant_sel;
            end else if (pop_en && head.last) begin
                drain_busy  <= 1'b0;        // Packet done, controller may grant again
                release_vec <= active_bit;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop_en) begin
            out_word <= head;
            out_port <= active;
        end
    end

    // The controller holds off while a packet is in flight
    a_no_grant_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n) grant |-> !drain_busy
    ) else $error("drain_engine: grant while busy");

endmodule

`default_nettype wire

//--- switch_top.sv
`default_nettype none

`include "switch_params.svh"

module switch_top (
    input  logic                  clk,
    input  logic                  rst_n,

    input  switch_pkg::pkt_word_t in_word [`SW_NUM_PORTS],
    input  switch_pkg::port_vec_t in_write,
    output switch_pkg::port_vec_t in_full,

    input  logic                  out_stall,
    output switch_pkg::pkt_word_t out_word,
    output logic                  out_valid,
    output switch_pkg::port_idx_t out_port,

    output logic                  idle
);

    import switch_pkg::*;

    port_vec_t fifo_empty;
    pkt_word_t fifo_head [`SW_NUM_PORTS];
    port_vec_t pop;
    port_vec_t release_vec;
    port_idx_t grant_sel;
    logic      grant;
    logic      drain_busy;

    // ==================================================
    // Port FIFOs
    // ==================================================

    for (genvar p = 0; p < `SW_NUM_PORTS; p++) begin : g_port
        sw_fifo #(
            .payload_t (pkt_word_t),
            .DEPTH     (`SW_FIFO_DEPTH)
        ) i_sw_fifo (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_en   (in_write[p]),
            .wr_data (in_word[p]),
            .rd_en   (pop[p]),
            .rd_data (fifo_head[p]),
            .empty   (fifo_empty[p]),
            .full    (in_full[p])
        );
    end

    // ==================================================
    // Scheduling and output
    // ==================================================

    service_ctrl i_service_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .fifo_empty  (fifo_empty),
        .drain_busy  (drain_busy),
        .release_vec (release_vec),
        .grant_sel   (grant_sel),
        .grant       (grant),
        .idle        (idle)
    );

    drain_engine i_drain_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .grant       (grant),
        .grant_sel   (grant_sel),
        .fifo_head   (fifo_head),
        .fifo_empty  (fifo_empty),
        .out_stall   (out_stall),
        .pop         (pop),
        .release_vec (release_vec),
        .drain_busy  (drain_busy),
        .out_word    (out_word),
        .out_valid   (out_valid),
        .out_port    (out_port)
    );

endmodule

`default_nettype wire

//--- tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    // Release between edges so that no process sees reset change on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- tb_checker.sv
`default_nettype none

`include "switch_params.svh"

module tb_checker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  switch_pkg::pkt_word_t in_word [`SW_NUM_PORTS],
    input  switch_pkg::port_vec_t in_write,
    input  switch_pkg::port_vec_t in_full,
    input  logic                  out_stall,
    input  switch_pkg::pkt_word_t out_word,
    input  logic                  out_valid,
    input  switch_pkg::port_idx_t out_port,
    input  logic                  idle,
    output int                    errors,
    output int                    words_checked,
    output logic                  model_empty
);
    timeunit 1ns;
    timeprecision 100ps;

    import switch_pkg::*;

    typedef struct packed {
        pkt_word_t   word;
        logic [31:0] cyc;  // Cycle in which the word was written
    } entry_t;

    entry_t      port_q [`SW_NUM_PORTS][$];  // Words written but not yet seen at the output
    int unsigned cyc;
    bit          reset_checked;
    bit          in_packet;
    port_idx_t   cur_port;
    int          bound;    // Port owed the next packet or SW_NUM_PORTS when there is none
    bit          stall_d;
    bit          full_exp;

    function automatic pkt_word_t expected_word(input port_idx_t p);
        return port_q[p][0].word;  // Oldest unsent word of that port
    endfunction

    task automatic report_mismatch(input string test, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("ERROR %s expected 0x%0h actual 0x%0h", test, exp, act);
        errors++;
    endtask

    task automatic check_output();
        pkt_word_t exp;
        words_checked++;
        if (stall_d) report_mismatch("stall_valid", 32'd0, 32'd1);
        if (in_packet && out_port != cur_port) begin
            report_mismatch("no_interleave", 32'(cur_port), 32'(out_port));
        end
        if (!in_packet) begin
            if (bound < `SW_NUM_PORTS && int'(out_port) != bound) begin
                report_mismatch("priority", 32'(bound), 32'(out_port));
            end
            in_packet = 1'b1;
            cur_port  = out_port;
        end
        if (port_q[out_port].size() == 0) begin
            $display("Port %0d sent a word that was never written to it", out_port);
            errors++;
        end else begin
            exp = expected_word(out_port);
            if (out_word != exp) report_mismatch("data_order", 32'(exp), 32'(out_word));
            void'(port_q[out_port].pop_front());
        end
        if (out_word.last) begin
            in_packet = 1'b0;
            bound     = `SW_NUM_PORTS;
            // A word written two cycles before this one has made its port pending
            for (int r = `SW_NUM_PORTS - 1; r >= 0; r--) begin
                if (r != int'(out_port) && port_q[r].size() != 0) begin
                    if (port_q[r][0].cyc + 2 <= cyc) bound = r;
                end
            end
        end
    endtask

    // ==================================================
    // Model update and compare on every clock edge
    // ==================================================

    always @(posedge clk) begin
        if (!rst_n) begin
            in_packet   = 1'b0;
            bound       = `SW_NUM_PORTS;
            stall_d     = 1'b0;
            model_empty = 1'b1;
        end else begin
            cyc++;
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (idle !== 1'b1) report_mismatch("reset_idle", 32'd1, 32'(idle));
                if (out_valid !== 1'b0) report_mismatch("reset_valid", 32'd0, 32'(out_valid));
            end
            if (out_valid) check_output();
            // Before this edge's writes the queue length is the fill that in_full shows
            for (int p = 0; p < `SW_NUM_PORTS; p++) begin
                full_exp = (port_q[p].size() == `SW_FIFO_DEPTH);
                if (in_full[p] !== full_exp) begin
                    report_mismatch("in_full", 32'(full_exp), 32'(in_full[p]));
                end
                if (in_write[p]) port_q[p].push_back(entry_t'{in_word[p], cyc});
            end
            stall_d     = out_stall;
            model_empty = 1'b1;
            for (int p = 0; p < `SW_NUM_PORTS; p++) begin
                if (port_q[p].size() != 0) model_empty = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_top.sv
`default_nettype none

`include "switch_params.svh"

module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    import switch_pkg::*;

    localparam int NUM_PACKETS = 80;
    localparam int WAIT_LIMIT  = 2000;

    logic      clk;
    logic      rst_n;
    pkt_word_t in_word [`SW_NUM_PORTS] = '{default: '0};
    port_vec_t in_write = '0;
    port_vec_t in_full;
    logic      out_stall = 1'b0;
    pkt_word_t out_word;
    logic      out_valid;
    port_idx_t out_port;
    logic      idle;
    int        errors;
    int        words_checked;
    logic      model_empty;
    int        timeouts;
    int        end_errors;
    bit        stim_done;

    tb_clock i_tb_clock (.clk(clk), .rst_n(rst_n));

    switch_top i_switch_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_word   (in_word),
        .in_write  (in_write),
        .in_full   (in_full),
        .out_stall (out_stall),
        .out_word  (out_word),
        .out_valid (out_valid),
        .out_port  (out_port),
        .idle      (idle)
    );

    tb_checker i_tb_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_word       (in_word),
        .in_write      (in_write),
        .in_full       (in_full),
        .out_stall     (out_stall),
        .out_word      (out_word),
        .out_valid     (out_valid),
        .out_port      (out_port),
        .idle          (idle),
        .errors        (errors),
        .words_checked (words_checked),
        .model_empty   (model_empty)
    );

    // ==================================================
    // Stimulus
    // ==================================================

    // Long stall bursts let several ports fill up behind the current packet
    always @(posedge clk) begin
        if (stim_done || !rst_n) begin
            out_stall <= 1'b0;
        end else if ($urandom_range(0, 7) == 0) begin
            out_stall <= !out_stall;
        end
    end

    // Each write is followed by a free cycle so that full is seen after the write lands
    task automatic write_word(input port_idx_t p, input pkt_word_t w);
        int n;
        n = 0;
        @(negedge clk);
        while (in_full[p] && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (in_full[p]) begin
            $display("Timeout: port %0d stayed full", p);
            timeouts++;
        end else begin
            @(posedge clk);
            in_word[p]  <= w;
            in_write[p] <= 1'b1;
            @(posedge clk);
            in_write[p] <= 1'b0;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        @(negedge clk);
        while (!(idle && model_empty) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!(idle && model_empty)) begin
            $display("Timeout: the switch did not send all written words");
            timeouts++;
        end
        repeat (10) @(negedge clk);
        if (idle !== 1'b1) begin
            $display("ERROR end_idle expected 0x1 actual 0x%0h", idle);
            end_errors++;
        end
        if (model_empty !== 1'b1) begin
            $display("ERROR end_queues expected 0x1 actual 0x%0h", model_empty);
            end_errors++;
        end
    endtask

    initial begin
        int        n;
        int        len;
        port_idx_t port;
        pkt_word_t w;
        void'($urandom(83345));
        n = 0;
        while (rst_n !== 1'b1 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout: reset was never released");
            timeouts++;
        end
        for (int k = 0; k < NUM_PACKETS; k++) begin
            port = port_idx_t'($urandom_range(0, `SW_NUM_PORTS - 1));
            len  = $urandom_range(1, 5);
            for (int i = 0; i < len; i++) begin
                w.data = 16'($urandom());
                w.last = (i == len - 1);
                write_word(port, w);
            end
            repeat ($urandom_range(0, 3)) @(posedge clk);
        end
        stim_done = 1'b1;
        wait_drain();
        $display("Checked %0d words: %0d compare errors, %0d end errors, %0d timeouts",
                 words_checked, errors, end_errors, timeouts);
        if (errors == 0 && end_errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
switch_pkg.sv
sw_fifo.sv
service_ctrl.sv
drain_engine.sv
switch_top.sv
tb_clock.sv
tb_checker.sv
tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, then look for the fail message in the log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f verilog.f \
    --Mdir obj_dir -o tb_top_sim > build.log 2>&1 \
    && ./obj_dir/tb_top_sim > sim.log 2>&1 \
    || { echo "Build or simulation run failed"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
